/* src/turbo_alu_defs.svh */
// Turbo ALU parameters
// Datapath widths and the clamp value for the LLR lanes

`ifndef TURBO_ALU_DEFS_SVH
`define TURBO_ALU_DEFS_SVH

// --------------------
// Scalar datapath
// --------------------

`define TA_XLEN    64

// --------------------
// SIMD lanes
// --------------------

// Eight signed LLRs packed in one word
`define TA_LANES   8
`define TA_LLR_W   8

// Positive ceiling for lane add and subtract
`define TA_SAT_MAX 63

`endif

/* src/turbo_alu_pkg.sv */
// Turbo ALU types
// Operation encoding and the dual view of a 64-bit operand,
// either one scalar word or eight signed LLR lanes

`default_nettype none

`include "turbo_alu_defs.svh"

package turbo_alu_pkg;

    // Top bit set selects the polar lane unit
    typedef enum logic [4:0] {
        ADD        = 5'h00,
        SUB        = 5'h01,
        ANDL       = 5'h02,
        ORL        = 5'h03,
        XORL       = 5'h04,
        SLL        = 5'h05,
        SRL        = 5'h06,
        SRA        = 5'h07,
        SLTS       = 5'h08,
        SLTU       = 5'h09,
        // Branch compares
        EQ         = 5'h0A,
        NE         = 5'h0B,
        LTS        = 5'h0C,
        LTU        = 5'h0D,
        GES        = 5'h0E,
        GEU        = 5'h0F,
        // Polar and LDN decoding
        LDN_MIN    = 5'h10,
        LDN_ADDSAT = 5'h11,
        LDN_SUBSAT = 5'h12,
        LDN_HMIN   = 5'h13
    } alu_op_e;

    // One log-likelihood ratio
    typedef logic signed [`TA_LLR_W-1:0] llr_t;

    // Lane 0 sits in bits 7:0
    typedef union packed {
        logic [`TA_XLEN-1:0]  word;
        llr_t [`TA_LANES-1:0] lane;
    } operand_u;

endpackage

`default_nettype wire

/* src/scalar_alu.sv */
// Scalar ALU
// Integer add and subtract, bitwise logic, shifts, set-less-than
// and branch resolution. Combinational, registered downstream

`default_nettype none

`include "turbo_alu_defs.svh"

module scalar_alu (
    input  turbo_alu_pkg::alu_op_e op_i,
    input  logic [`TA_XLEN-1:0]    operand_a_i,
    input  logic [`TA_XLEN-1:0]    operand_b_i,
    output logic [`TA_XLEN-1:0]    result_o,
    output logic                   branch_res_o
);

    localparam int SHAMT_W = $clog2(`TA_XLEN);

    logic [`TA_XLEN-1:0] operand_a_rev;

    // --------------------
    // Adder
    // --------------------
    logic                adder_negate;
    logic [`TA_XLEN:0]   adder_in_a;
    logic [`TA_XLEN:0]   adder_in_b;
    logic [`TA_XLEN:0]   adder_sum;
    logic [`TA_XLEN-1:0] adder_result;
    logic                adder_zero;

    always_comb begin
        case (op_i)
            turbo_alu_pkg::SUB,
            turbo_alu_pkg::EQ,
            turbo_alu_pkg::NE: adder_negate = 1'b1;
            default:           adder_negate = 1'b0;
        endcase
    end

    // Extra low bit turns the inverted b into a two's complement negate
    assign adder_in_a   = {operand_a_i, 1'b1};
    assign adder_in_b   = {operand_b_i, 1'b0} ^ {(`TA_XLEN + 1){adder_negate}};
    assign adder_sum    = adder_in_a + adder_in_b;
    assign adder_result = adder_sum[`TA_XLEN:1];
    assign adder_zero   = ~|adder_result;

    // --------------------
    // Shifter
    // --------------------
    logic                shift_left;
    logic                shift_arith;
    logic [SHAMT_W-1:0]  shift_amt;
    logic [`TA_XLEN-1:0] shift_op_a;
    logic [`TA_XLEN:0]   shift_right_ext;
    logic [`TA_XLEN-1:0] shift_right_result;
    logic [`TA_XLEN-1:0] shift_left_result;
    logic [`TA_XLEN-1:0] shift_result;

    always_comb begin
        for (int k = 0; k < `TA_XLEN; k++) begin
            operand_a_rev[k] = operand_a_i[`TA_XLEN-1-k];
        end
    end

    assign shift_left  = (op_i == turbo_alu_pkg::SLL);
    assign shift_arith = (op_i == turbo_alu_pkg::SRA);
    assign shift_amt   = operand_b_i[SHAMT_W-1:0];

    // Left shift is a right shift of the reversed operand
    assign shift_op_a = shift_left ? operand_a_rev : operand_a_i;

    // Sign fill only for SRA
    assign shift_right_ext = $unsigned(
        $signed({shift_arith & shift_op_a[`TA_XLEN-1], shift_op_a}) >>> shift_amt);
    assign shift_right_result = shift_right_ext[`TA_XLEN-1:0];

    always_comb begin
        for (int k = 0; k < `TA_XLEN; k++) begin
            shift_left_result[k] = shift_right_result[`TA_XLEN-1-k];
        end
    end

    assign shift_result = shift_left ? shift_left_result : shift_right_result;

    // --------------------
    // Comparator
    // --------------------
    logic cmp_signed;
    logic less;

    assign cmp_signed = (op_i == turbo_alu_pkg::SLTS) ||
                        (op_i == turbo_alu_pkg::LTS)  ||
                        (op_i == turbo_alu_pkg::GES);

    // One extra bit, sign or zero, covers both compare flavours
    assign less = $signed({cmp_signed & operand_a_i[`TA_XLEN-1], operand_a_i}) <
                  $signed({cmp_signed & operand_b_i[`TA_XLEN-1], operand_b_i});

    always_comb begin
        case (op_i)
            turbo_alu_pkg::EQ:  branch_res_o = adder_zero;
            turbo_alu_pkg::NE:  branch_res_o = ~adder_zero;
            turbo_alu_pkg::LTS,
            turbo_alu_pkg::LTU: branch_res_o = less;
            turbo_alu_pkg::GES,
            turbo_alu_pkg::GEU: branch_res_o = ~less;
            default:            branch_res_o = 1'b1;
        endcase
    end

    // --------------------
    // Result mux
    // --------------------
    always_comb begin
        case (op_i)
            turbo_alu_pkg::ADD,
            turbo_alu_pkg::SUB:  result_o = adder_result;
            turbo_alu_pkg::ANDL: result_o = operand_a_i & operand_b_i;
            turbo_alu_pkg::ORL:  result_o = operand_a_i | operand_b_i;
            turbo_alu_pkg::XORL: result_o = operand_a_i ^ operand_b_i;
            turbo_alu_pkg::SLL,
            turbo_alu_pkg::SRL,
            turbo_alu_pkg::SRA:  result_o = shift_result;
            turbo_alu_pkg::SLTS,
            turbo_alu_pkg::SLTU: result_o = {{(`TA_XLEN - 1){1'b0}}, less};
            // Branches and polar codes leave the word at zero
            default:             result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/polar_simd_unit.sv */
// Polar SIMD lane unit
// Eight signed LLR lanes per operand. Lane-wise min, saturating
// add and subtract, and a horizontal minimum. Combinational

`default_nettype none

`include "turbo_alu_defs.svh"

module polar_simd_unit (
    input  turbo_alu_pkg::alu_op_e  op_i,
    input  turbo_alu_pkg::operand_u operand_a_i,
    input  turbo_alu_pkg::operand_u operand_b_i,
    output logic [`TA_XLEN-1:0]     result_o
);

    localparam turbo_alu_pkg::llr_t LLR_SAT = `TA_SAT_MAX;

    turbo_alu_pkg::operand_u min_vec;
    turbo_alu_pkg::operand_u addsat_vec;
    turbo_alu_pkg::operand_u subsat_vec;

    // One guard bit per lane to see the overflow
    logic signed [`TA_LLR_W:0] lane_sum  [`TA_LANES];
    logic signed [`TA_LLR_W:0] lane_diff [`TA_LANES];

    // Horizontal min tree
    turbo_alu_pkg::llr_t min_l1 [`TA_LANES/2];
    turbo_alu_pkg::llr_t min_l2 [`TA_LANES/4];
    turbo_alu_pkg::llr_t min_l3;
    turbo_alu_pkg::llr_t hmin;

    function automatic turbo_alu_pkg::llr_t llr_min(input turbo_alu_pkg::llr_t x,
                                                    input turbo_alu_pkg::llr_t y);
        return (x < y) ? x : y;
    endfunction

    // --------------------
    // Per-lane ops
    // --------------------
    always_comb begin
        for (int i = 0; i < `TA_LANES; i++) begin
            lane_sum[i]  = $signed(operand_a_i.lane[i]) + $signed(operand_b_i.lane[i]);
            lane_diff[i] = $signed(operand_a_i.lane[i]) - $signed(operand_b_i.lane[i]);

            min_vec.lane[i] = llr_min(operand_a_i.lane[i], operand_b_i.lane[i]);

            // Clamp only on the positive side, else plain truncation
            addsat_vec.lane[i] = (lane_sum[i] > LLR_SAT) ? LLR_SAT :
                                 lane_sum[i][`TA_LLR_W-1:0];
            subsat_vec.lane[i] = (lane_diff[i] > LLR_SAT) ? LLR_SAT :
                                 lane_diff[i][`TA_LLR_W-1:0];
        end
    end

    // --------------------
    // Horizontal min
    // --------------------
    always_comb begin
        for (int j = 0; j < `TA_LANES/2; j++) begin
            min_l1[j] = llr_min(operand_a_i.lane[2*j], operand_a_i.lane[2*j+1]);
        end
        for (int j = 0; j < `TA_LANES/4; j++) begin
            min_l2[j] = llr_min(min_l1[2*j], min_l1[2*j+1]);
        end
        min_l3 = llr_min(min_l2[0], min_l2[1]);
    end

    // b lane 0 joins after the tree
    assign hmin = llr_min(min_l3, operand_b_i.lane[0]);

    always_comb begin
        case (op_i)
            turbo_alu_pkg::LDN_MIN:    result_o = min_vec.word;
            turbo_alu_pkg::LDN_ADDSAT: result_o = addsat_vec.word;
            turbo_alu_pkg::LDN_SUBSAT: result_o = subsat_vec.word;
            turbo_alu_pkg::LDN_HMIN:
                result_o = {{(`TA_XLEN - `TA_LLR_W){hmin[`TA_LLR_W-1]}}, hmin};
            default:                   result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* src/alu_result_sel.sv */
// ALU result stage
// Picks the scalar or polar result by the op class bit and
// registers result, branch flag and valid

`default_nettype none

`include "turbo_alu_defs.svh"

module alu_result_sel (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   valid_i,
    input  turbo_alu_pkg::alu_op_e op_i,
    input  logic [`TA_XLEN-1:0]    scalar_result_i,
    input  logic [`TA_XLEN-1:0]    polar_result_i,
    input  logic                   branch_res_i,
    output logic                   valid_o,
    output logic [`TA_XLEN-1:0]    result_o,
    output logic                   branch_res_o
);

    localparam int OP_CLASS_BIT = $bits(turbo_alu_pkg::alu_op_e) - 1;

    logic                is_polar;
    logic [`TA_XLEN-1:0] result_sel;

    assign is_polar   = op_i[OP_CLASS_BIT];
    assign result_sel = is_polar ? polar_result_i : scalar_result_i;

    // Result holds over idle cycles
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o      <= 1'b0;
            result_o     <= '0;
            branch_res_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                result_o     <= result_sel;
                branch_res_o <= branch_res_i;
            end
        end
    end

    // --------------------
    // Assertions
    // --------------------
    function automatic logic lanes_in_range(input logic [`TA_XLEN-1:0] w);
        turbo_alu_pkg::operand_u v;
        logic                    ok;
        v.word = w;
        ok     = 1'b1;
        for (int i = 0; i < `TA_LANES; i++) begin
            if (v.lane[i] > `TA_SAT_MAX) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    a_op_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i |-> !$isunknown(op_i))
        else $error("op_i unknown with valid_i high");

    a_valid_after_reset: assert property (@(posedge clk_i)
        $rose(arst_n_i) |-> !valid_o)
        else $error("valid_o high right after reset release");

    // Saturating ops never leave a lane above the ceiling
    a_sat_ceiling: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i && is_polar &&
        (op_i inside {turbo_alu_pkg::LDN_ADDSAT, turbo_alu_pkg::LDN_SUBSAT})
        |=> lanes_in_range(result_o))
        else $error("saturated lane above ceiling in result_o");

endmodule

`default_nettype wire

/* src/turbo_alu.sv */
// Turbo ALU top level
// Scalar ALU and polar SIMD unit side by side, with one
// registered result stage. One operation per cycle

`default_nettype none

`include "turbo_alu_defs.svh"

module turbo_alu (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   valid_i,
    input  turbo_alu_pkg::alu_op_e op_i,
    input  logic [`TA_XLEN-1:0]    operand_a_i,
    input  logic [`TA_XLEN-1:0]    operand_b_i,
    output logic                   valid_o,
    output logic [`TA_XLEN-1:0]    result_o,
    output logic                   branch_res_o
);

    logic [`TA_XLEN-1:0] scalar_result;
    logic [`TA_XLEN-1:0] polar_result;
    logic                branch_res;

    // Both compute blocks see every operation
    scalar_alu u_scalar_alu (
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .result_o     (scalar_result),
        .branch_res_o (branch_res)
    );

    polar_simd_unit u_polar_simd_unit (
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .result_o    (polar_result)
    );

    alu_result_sel u_alu_result_sel (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .valid_i         (valid_i),
        .op_i            (op_i),
        .scalar_result_i (scalar_result),
        .polar_result_i  (polar_result),
        .branch_res_i    (branch_res),
        .valid_o         (valid_o),
        .result_o        (result_o),
        .branch_res_o    (branch_res_o)
    );

endmodule

`default_nettype wire

/* tb/alu_ref_model.svh */
// Reference model for the turbo ALU testbench
// Expected result word and branch flag for one operation

`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// Positive clamp, else keep the low eight bits
function automatic turbo_alu_pkg::llr_t clamp_lane(input int s);
    return (s > `TA_SAT_MAX) ? `TA_SAT_MAX : s[7:0];
endfunction

function automatic logic [`TA_XLEN-1:0] expect_result(input turbo_alu_pkg::alu_op_e op,
                                                      input logic [`TA_XLEN-1:0] a,
                                                      input logic [`TA_XLEN-1:0] b);
    turbo_alu_pkg::operand_u la;
    turbo_alu_pkg::operand_u lb;
    turbo_alu_pkg::operand_u lr;
    turbo_alu_pkg::llr_t     m;
    la.word = a;
    lb.word = b;
    lr.word = '0;
    case (op)
        turbo_alu_pkg::ADD:  return a + b;
        turbo_alu_pkg::SUB:  return a - b;
        turbo_alu_pkg::ANDL: return a & b;
        turbo_alu_pkg::ORL:  return a | b;
        turbo_alu_pkg::XORL: return a ^ b;
        turbo_alu_pkg::SLL:  return a << b[5:0];
        turbo_alu_pkg::SRL:  return a >> b[5:0];
        turbo_alu_pkg::SRA:  return $unsigned($signed(a) >>> b[5:0]);
        turbo_alu_pkg::SLTS: return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        turbo_alu_pkg::SLTU: return (a < b) ? 64'd1 : 64'd0;
        turbo_alu_pkg::LDN_MIN: begin
            for (int i = 0; i < `TA_LANES; i++) begin
                lr.lane[i] = (la.lane[i] < lb.lane[i]) ? la.lane[i] : lb.lane[i];
            end
            return lr.word;
        end
        turbo_alu_pkg::LDN_ADDSAT: begin
            for (int i = 0; i < `TA_LANES; i++) begin
                lr.lane[i] = clamp_lane(int'(la.lane[i]) + int'(lb.lane[i]));
            end
            return lr.word;
        end
        turbo_alu_pkg::LDN_SUBSAT: begin
            for (int i = 0; i < `TA_LANES; i++) begin
                lr.lane[i] = clamp_lane(int'(la.lane[i]) - int'(lb.lane[i]));
            end
            return lr.word;
        end
        turbo_alu_pkg::LDN_HMIN: begin
            // Linear scan, b lane 0 as the start value
            m = lb.lane[0];
            for (int i = 0; i < `TA_LANES; i++) begin
                if (la.lane[i] < m) begin
                    m = la.lane[i];
                end
            end
            return {{(`TA_XLEN - `TA_LLR_W){m[`TA_LLR_W-1]}}, m};
        end
        default: return '0;
    endcase
endfunction

function automatic logic expect_branch(input turbo_alu_pkg::alu_op_e op,
                                       input logic [`TA_XLEN-1:0] a,
                                       input logic [`TA_XLEN-1:0] b);
    case (op)
        turbo_alu_pkg::EQ:  return a == b;
        turbo_alu_pkg::NE:  return a != b;
        turbo_alu_pkg::LTS: return $signed(a) < $signed(b);
        turbo_alu_pkg::LTU: return a < b;
        turbo_alu_pkg::GES: return $signed(a) >= $signed(b);
        turbo_alu_pkg::GEU: return a >= b;
        default:            return 1'b1;
    endcase
endfunction

`endif

/* tb/tb_turbo_alu.sv */
// Testbench for the turbo ALU
// Directed and random operations feed a one-deep expected register,
// concurrent assertions compare every registered output

`default_nettype none

`include "turbo_alu_defs.svh"

module tb_turbo_alu;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 10;
    localparam int RANDOM_OPS   = 400;
    // Reset, directed cases, random ops with idle gaps, plus margin
    localparam int MAX_CYCLES   = 600;

    logic                   clk_i;
    logic                   arst_n_i;
    logic                   valid_i;
    turbo_alu_pkg::alu_op_e op_i;
    logic [`TA_XLEN-1:0]    operand_a_i;
    logic [`TA_XLEN-1:0]    operand_b_i;
    logic                   valid_o;
    logic [`TA_XLEN-1:0]    result_o;
    logic                   branch_res_o;

    logic                exp_valid;
    logic [`TA_XLEN-1:0] exp_result;
    logic                exp_branch;
    int                  errors;
    int                  cycles;

    `include "alu_ref_model.svh"

    turbo_alu u_turbo_alu (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .op_i         (op_i),
        .operand_a_i  (operand_a_i),
        .operand_b_i  (operand_b_i),
        .valid_o      (valid_o),
        .result_o     (result_o),
        .branch_res_o (branch_res_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // Expected register
    // --------------------
    always @(posedge clk_i) begin
        if (!arst_n_i) begin
            exp_valid  <= 1'b0;
            exp_result <= '0;
            exp_branch <= 1'b0;
        end else begin
            exp_valid <= valid_i;
            if (valid_i) begin
                exp_result <= expect_result(op_i, operand_a_i, operand_b_i);
                exp_branch <= expect_branch(op_i, operand_a_i, operand_b_i);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // --------------------
    // Checks
    // --------------------
    valid_matches: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o == exp_valid)
        else begin
            errors++;
            $display("ERROR %0t valid_o expected %b got %b",
                     $time, $sampled(exp_valid), $sampled(valid_o));
        end

    result_matches: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        result_o == exp_result)
        else begin
            errors++;
            $display("ERROR %0t result_o expected %h got %h",
                     $time, $sampled(exp_result), $sampled(result_o));
        end

    branch_matches: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        branch_res_o == exp_branch)
        else begin
            errors++;
            $display("ERROR %0t branch_res_o expected %b got %b",
                     $time, $sampled(exp_branch), $sampled(branch_res_o));
        end

    idle_drops_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !valid_i |=> !valid_o)
        else begin
            errors++;
            $display("valid_o stayed high after an idle cycle at %0t", $time);
        end

    reset_clears_outputs: assert property (@(posedge clk_i)
        $rose(arst_n_i) |-> !valid_o && result_o == '0 && !branch_res_o)
        else begin
            errors++;
            $display("Outputs not cleared when reset was released at %0t", $time);
        end

    // --------------------
    // Stimulus
    // --------------------
    task automatic drive_op(input turbo_alu_pkg::alu_op_e op,
                            input logic [`TA_XLEN-1:0] a,
                            input logic [`TA_XLEN-1:0] b);
        @(posedge clk_i);
        #DRIVE_DELAY;
        valid_i     = 1'b1;
        op_i        = op;
        operand_a_i = a;
        operand_b_i = b;
    endtask

    task automatic drive_idle();
        @(posedge clk_i);
        #DRIVE_DELAY;
        valid_i = 1'b0;
    endtask

    function automatic logic [`TA_XLEN-1:0] rand_word();
        return {$urandom(), $urandom()};
    endfunction

    // Lanes limited to -64..63 so a sum or difference never wraps below -128
    function automatic logic [`TA_XLEN-1:0] narrow_lanes(input logic [`TA_XLEN-1:0] w);
        logic [`TA_XLEN-1:0] r;
        r = w;
        for (int i = 0; i < `TA_LANES; i++) begin
            r[i*`TA_LLR_W + 7] = r[i*`TA_LLR_W + 6];
        end
        return r;
    endfunction

    task automatic run_directed();
        logic [`TA_XLEN-1:0] sh_a;
        sh_a = 64'h8000_0000_F00D_0001;
        drive_op(turbo_alu_pkg::EQ,  64'h1234_5678_9ABC_DEF0, 64'h1234_5678_9ABC_DEF0);
        drive_op(turbo_alu_pkg::NE,  64'h1234_5678_9ABC_DEF0, 64'h1234_5678_9ABC_DEF0);
        drive_op(turbo_alu_pkg::GES, 64'hFFFF_FFFF_FFFF_FFFE, 64'hFFFF_FFFF_FFFF_FFFE);
        drive_op(turbo_alu_pkg::GEU, 64'h0000_0000_0000_0005, 64'h0000_0000_0000_0005);
        drive_op(turbo_alu_pkg::SLTS, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1);
        drive_op(turbo_alu_pkg::SLTU, 64'hFFFF_FFFF_FFFF_FFFF, 64'h1);
        // Sums and differences at and just above the ceiling
        drive_op(turbo_alu_pkg::LDN_ADDSAT, 64'h201F_3F01_403E_00C0, 64'h2020_003F_0001_3FC0);
        drive_op(turbo_alu_pkg::LDN_SUBSAT, 64'h201F_3F01_403E_00C0, 64'hE0E1_01C1_00FF_0140);
        drive_op(turbo_alu_pkg::LDN_MIN,  64'h7F80_0102_FE05_C040, 64'h0081_0201_FF04_C13F);
        drive_op(turbo_alu_pkg::LDN_HMIN, 64'h1020_3040_5060_7001, 64'h0000_0000_0000_00F0);
        for (int s = 0; s < 2; s++) begin
            drive_op(turbo_alu_pkg::SLL, sh_a, (s == 0) ? 64'd0 : 64'd63);
            drive_op(turbo_alu_pkg::SRL, sh_a, (s == 0) ? 64'd0 : 64'd63);
            drive_op(turbo_alu_pkg::SRA, sh_a, (s == 0) ? 64'd0 : 64'd63);
        end
    endtask

    task automatic random_op();
        turbo_alu_pkg::alu_op_e op;
        logic [`TA_XLEN-1:0]    a;
        logic [`TA_XLEN-1:0]    b;
        op = turbo_alu_pkg::alu_op_e'(5'($urandom_range(19, 0)));
        a  = rand_word();
        b  = rand_word();
        // Equal operands now and then for the EQ, NE and GE edges
        if ($urandom_range(3, 0) == 0) begin
            b = a;
        end
        if (op inside {turbo_alu_pkg::LDN_ADDSAT, turbo_alu_pkg::LDN_SUBSAT}) begin
            a = narrow_lanes(a);
            b = narrow_lanes(b);
        end
        drive_op(op, a, b);
    endtask

    initial begin
        clk_i       = 1'b0;
        arst_n_i    = 1'b0;
        valid_i     = 1'b0;
        op_i        = turbo_alu_pkg::ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        errors      = 0;
        cycles      = 0;
        void'($urandom(23));

        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        arst_n_i = 1'b1;

        run_directed();
        for (int n = 0; n < RANDOM_OPS; n++) begin
            // About one idle cycle in eight
            if ($urandom_range(7, 0) == 0) begin
                drive_idle();
            end
            random_op();
        end
        drive_idle();
        repeat (2) @(posedge clk_i);

        $display("Run complete after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* turbo_alu.f */
+incdir+src
+incdir+tb
src/turbo_alu_pkg.sv
src/scalar_alu.sv
src/polar_simd_unit.sv
src/alu_result_sel.sv
src/turbo_alu.sv
tb/tb_turbo_alu.sv

/* run_sim.sh */
#!/bin/sh
# Build the turbo ALU testbench with Verilator, run it, and check the log

rm -f build.log sim.log &&
verilator --binary --timing --assert -Wno-fatal \
    -f turbo_alu.f --top-module tb_turbo_alu \
    -o sim_turbo_alu > build.log 2>&1 &&
./obj_dir/sim_turbo_alu > sim.log 2>&1

grep -q "^Test passed$" sim.log &&
    echo "Simulation passed, see sim.log" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }
